/* verilog/id_pkg.sv */
package id_pkg;

	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;

	typedef logic [DATA_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [7:0]            aluop_t;
	typedef logic [2:0]            alusel_t;

	localparam aluop_t ALU_NOP   = 8'b00000000;
	localparam aluop_t ALU_OR    = 8'b00100101;
	localparam aluop_t ALU_AND   = 8'b00100100;
	localparam aluop_t ALU_XOR   = 8'b00100110;
	localparam aluop_t ALU_NOR   = 8'b00100111;
	localparam aluop_t ALU_SLL   = 8'b01111100;
	localparam aluop_t ALU_SRL   = 8'b00000010;
	localparam aluop_t ALU_SRA   = 8'b00000011;
	localparam aluop_t ALU_SLT   = 8'b00101010;
	localparam aluop_t ALU_SLTU  = 8'b00101011;
	localparam aluop_t ALU_ADD   = 8'b00100000;
	localparam aluop_t ALU_ADDU  = 8'b00100001;
	localparam aluop_t ALU_SUB   = 8'b00100010;
	localparam aluop_t ALU_SUBU  = 8'b00100011;
	localparam aluop_t ALU_ADDI  = 8'b01010101;
	localparam aluop_t ALU_ADDIU = 8'b01010110;
	localparam aluop_t ALU_MOVN  = 8'b00001011;
	localparam aluop_t ALU_MOVZ  = 8'b00001010;
	localparam aluop_t ALU_CLZ   = 8'b10110000;
	localparam aluop_t ALU_CLO   = 8'b10110001;

	localparam alusel_t SEL_NOP   = 3'b000;
	localparam alusel_t SEL_LOGIC = 3'b001;
	localparam alusel_t SEL_SHIFT = 3'b010;
	localparam alusel_t SEL_MOVE  = 3'b011;
	localparam alusel_t SEL_ARITH = 3'b100;

	localparam logic [5:0] OP_SPECIAL  = 6'b000000;
	localparam logic [5:0] OP_SPECIAL2 = 6'b011100;
	localparam logic [5:0] OP_ORI      = 6'b001101;
	localparam logic [5:0] OP_ANDI     = 6'b001100;
	localparam logic [5:0] OP_XORI     = 6'b001110;
	localparam logic [5:0] OP_LUI      = 6'b001111;
	localparam logic [5:0] OP_SLTI     = 6'b001010;
	localparam logic [5:0] OP_SLTIU    = 6'b001011;
	localparam logic [5:0] OP_ADDI     = 6'b001000;
	localparam logic [5:0] OP_ADDIU    = 6'b001001;

	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_MOVZ = 6'b001010;
	localparam logic [5:0] FN_MOVN = 6'b001011;
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;
	localparam logic [5:0] FN_CLZ  = 6'b100000; // special2 space
	localparam logic [5:0] FN_CLO  = 6'b100001;

	typedef struct packed {
		logic [5:0] op;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] sa;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  op;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm16;
	} i_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} inst_u;

	typedef struct packed {
		logic      wreg;
		reg_addr_t wd;
		word_t     wdata;
	} fwd_t;

	typedef struct packed {
		logic      we;
		reg_addr_t waddr;
		word_t     wdata;
	} wb_t;

	typedef struct packed {
		word_t     pc;
		aluop_t    aluop;
		alusel_t   alusel;
		word_t     reg1;
		word_t     reg2;
		reg_addr_t wd;
		logic      wreg;
		logic      illegal;
	} id_out_t;

endpackage

/* verilog/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder import id_pkg::*; (
	input  inst_u     inst_i,
	input  word_t     rt_value_i,
	output aluop_t    aluop_o,
	output alusel_t   alusel_o,
	output logic      wreg_o,
	output reg_addr_t wd_o,
	output logic      reg1_read_o,
	output logic      reg2_read_o,
	output reg_addr_t reg1_addr_o,
	output reg_addr_t reg2_addr_o,
	output word_t     imm_o,
	output logic      illegal_o
);

	logic  form_rr; // reads rs and rt, writes rd
	logic  form_ri; // reads rs, writes rt
	logic  form_sh; // fixed shift, reads rt
	logic  form_r1; // reads rs, writes rd
	logic  is_movn;
	logic  is_movz;
	logic  wreg_dec;
	logic  fixed_shift;
	word_t imm_zext;
	word_t imm_sext;
	word_t imm_lui;

	assign imm_zext = {16'h0000, inst_i.i.imm16};
	assign imm_sext = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};
	assign imm_lui  = {inst_i.i.imm16, 16'h0000};

	assign fixed_shift = (inst_i.r.rs == '0) &&
		(inst_i.r.funct == FN_SLL || inst_i.r.funct == FN_SRL || inst_i.r.funct == FN_SRA);

	always_comb begin
		aluop_o     = ALU_NOP;
		alusel_o    = SEL_NOP;
		form_rr     = 1'b0;
		form_ri     = 1'b0;
		form_sh     = 1'b0;
		form_r1     = 1'b0;
		is_movn     = 1'b0;
		is_movz     = 1'b0;
		wd_o        = inst_i.r.rd;
		reg1_addr_o = inst_i.r.rs;
		reg2_addr_o = inst_i.r.rt;
		reg1_read_o = 1'b0;
		reg2_read_o = 1'b0;
		imm_o       = '0;
		case (inst_i.r.op)
			OP_SPECIAL: begin
				if (fixed_shift) begin
					form_sh  = 1'b1;
					alusel_o = SEL_SHIFT;
					case (inst_i.r.funct)
						FN_SLL:  aluop_o = ALU_SLL;
						FN_SRL:  aluop_o = ALU_SRL;
						default: aluop_o = ALU_SRA;
					endcase
				end else if (inst_i.r.sa == '0) begin
					form_rr = 1'b1;
					case (inst_i.r.funct)
						FN_OR:   {aluop_o, alusel_o} = {ALU_OR, SEL_LOGIC};
						FN_AND:  {aluop_o, alusel_o} = {ALU_AND, SEL_LOGIC};
						FN_XOR:  {aluop_o, alusel_o} = {ALU_XOR, SEL_LOGIC};
						FN_NOR:  {aluop_o, alusel_o} = {ALU_NOR, SEL_LOGIC};
						FN_SLLV: {aluop_o, alusel_o} = {ALU_SLL, SEL_SHIFT};
						FN_SRLV: {aluop_o, alusel_o} = {ALU_SRL, SEL_SHIFT};
						FN_SRAV: {aluop_o, alusel_o} = {ALU_SRA, SEL_SHIFT};
						FN_SLT:  {aluop_o, alusel_o} = {ALU_SLT, SEL_ARITH};
						FN_SLTU: {aluop_o, alusel_o} = {ALU_SLTU, SEL_ARITH};
						FN_ADD:  {aluop_o, alusel_o} = {ALU_ADD, SEL_ARITH};
						FN_ADDU: {aluop_o, alusel_o} = {ALU_ADDU, SEL_ARITH};
						FN_SUB:  {aluop_o, alusel_o} = {ALU_SUB, SEL_ARITH};
						FN_SUBU: {aluop_o, alusel_o} = {ALU_SUBU, SEL_ARITH};
						FN_MOVN: begin
							{aluop_o, alusel_o} = {ALU_MOVN, SEL_MOVE};
							is_movn = 1'b1;
						end
						FN_MOVZ: begin
							{aluop_o, alusel_o} = {ALU_MOVZ, SEL_MOVE};
							is_movz = 1'b1;
						end
						default: form_rr = 1'b0; // sync lands here too
					endcase
				end
			end
			OP_SPECIAL2: begin
				form_r1 = 1'b1;
				case (inst_i.r.funct)
					FN_CLZ:  {aluop_o, alusel_o} = {ALU_CLZ, SEL_ARITH};
					FN_CLO:  {aluop_o, alusel_o} = {ALU_CLO, SEL_ARITH};
					default: form_r1 = 1'b0;
				endcase
			end
			OP_ORI: begin
				{aluop_o, alusel_o} = {ALU_OR, SEL_LOGIC};
				imm_o = imm_zext;
				form_ri = 1'b1;
			end
			OP_ANDI: begin
				{aluop_o, alusel_o} = {ALU_AND, SEL_LOGIC};
				imm_o = imm_zext;
				form_ri = 1'b1;
			end
			OP_XORI: begin
				{aluop_o, alusel_o} = {ALU_XOR, SEL_LOGIC};
				imm_o = imm_zext;
				form_ri = 1'b1;
			end
			OP_LUI: begin
				{aluop_o, alusel_o} = {ALU_OR, SEL_LOGIC}; // rs or upper immediate
				imm_o = imm_lui;
				form_ri = 1'b1;
			end
			OP_SLTI: begin
				{aluop_o, alusel_o} = {ALU_SLT, SEL_ARITH};
				imm_o = imm_sext;
				form_ri = 1'b1;
			end
			OP_SLTIU: begin
				{aluop_o, alusel_o} = {ALU_SLTU, SEL_ARITH};
				imm_o = imm_sext;
				form_ri = 1'b1;
			end
			OP_ADDI: begin
				{aluop_o, alusel_o} = {ALU_ADDI, SEL_ARITH};
				imm_o = imm_sext;
				form_ri = 1'b1;
			end
			OP_ADDIU: begin
				{aluop_o, alusel_o} = {ALU_ADDIU, SEL_ARITH};
				imm_o = imm_sext;
				form_ri = 1'b1;
			end
			default: begin
			end
		endcase
		if (form_rr || form_ri || form_r1) begin
			reg1_read_o = 1'b1;
		end
		if (form_rr || form_sh) begin
			reg2_read_o = 1'b1;
		end
		if (form_ri) begin
			wd_o = inst_i.i.rt;
		end
		if (form_sh) begin
			imm_o[4:0] = inst_i.r.sa; // shift amount goes out on reg1
		end
	end

	assign illegal_o = !(form_rr || form_ri || form_sh || form_r1);
	assign wreg_dec  = !illegal_o && !is_movn && !is_movz;

	// movn/movz resolve on the forwarded rt value
	assign wreg_o = wreg_dec || (is_movn && (rt_value_i != '0)) ||
		(is_movz && (rt_value_i == '0));

	always_comb begin
		assert final (!(illegal_o && wreg_o))
			else $error("illegal instruction requests a register write");
	end

endmodule

/* verilog/operand_fwd.sv */
`timescale 1ns/1ps

module operand_fwd import id_pkg::*; (
	input  logic      read_i,
	input  reg_addr_t addr_i,
	input  word_t     rf_data_i,
	input  word_t     imm_i,
	input  fwd_t      ex_fwd_i,
	input  fwd_t      mem_fwd_i,
	output word_t     operand_o
);

	logic ex_hit;
	logic mem_hit;

	// r0 is forwarded like any other register
	assign ex_hit  = read_i && ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
	assign mem_hit = read_i && mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

	always_comb begin
		if (ex_hit) begin
			operand_o = ex_fwd_i.wdata; // newest result wins
		end else if (mem_hit) begin
			operand_o = mem_fwd_i.wdata;
		end else if (read_i) begin
			operand_o = rf_data_i;
		end else begin
			operand_o = imm_i;
		end
	end

endmodule

/* verilog/regfile.sv */
`timescale 1ns/1ps

module regfile import id_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	input  wb_t       wb_i,
	input  reg_addr_t raddr1_i,
	input  reg_addr_t raddr2_i,
	output word_t     rdata1_o,
	output word_t     rdata2_o
);

	word_t regs [NUM_REGS];
	logic  wr_en;

	assign wr_en = wb_i.we && (wb_i.waddr != '0); // r0 never written

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb_i.waddr] <= wb_i.wdata;
		end
	end

	// write-through so a same-cycle writeback is visible
	always_comb begin
		rdata1_o = regs[raddr1_i];
		if (wr_en && (wb_i.waddr == raddr1_i)) begin
			rdata1_o = wb_i.wdata;
		end
	end

	always_comb begin
		rdata2_o = regs[raddr2_i];
		if (wr_en && (wb_i.waddr == raddr2_i)) begin
			rdata2_o = wb_i.wdata;
		end
	end

endmodule

/* verilog/id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg import id_pkg::*; (
	input  logic    clk_i,
	input  logic    rst_n_i,
	input  logic    in_valid_i,
	output logic    in_ready_o,
	input  id_out_t in_data_i,
	output logic    out_valid_o,
	input  logic    out_ready_i,
	output id_out_t out_data_o
);

	logic    valid_q;
	id_out_t data_q;

	// free slot or the current bundle leaves this cycle
	assign in_ready_o = !valid_q || out_ready_i;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else if (in_ready_o) begin
			valid_q <= in_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (in_ready_o) begin
			data_q <= in_data_i;
		end
	end

	assign out_valid_o = valid_q;
	assign out_data_o  = data_q;

	// a stalled bundle stays put until downstream takes it
	hold_while_stalled: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o)
	) else $error("output bundle changed while stalled");

endmodule

/* verilog/id_stage.sv */
`timescale 1ns/1ps

module id_stage import id_pkg::*; (
	input  logic    clk_i,
	input  logic    rst_n_i,
	input  logic    in_valid_i,
	output logic    in_ready_o,
	input  word_t   in_pc_i,
	input  word_t   in_inst_i,
	input  fwd_t    ex_fwd_i,
	input  fwd_t    mem_fwd_i,
	input  wb_t     wb_i,
	output logic    out_valid_o,
	input  logic    out_ready_i,
	output id_out_t out_o
);

	aluop_t    aluop;
	alusel_t   alusel;
	logic      wreg;
	reg_addr_t wd;
	logic      reg1_read;
	logic      reg2_read;
	reg_addr_t reg1_addr;
	reg_addr_t reg2_addr;
	word_t     imm;
	logic      illegal;
	word_t     rf_data1;
	word_t     rf_data2;
	word_t     reg1;
	word_t     reg2;
	id_out_t   dec_bundle;

	inst_decoder u_dec (
		.inst_i      (inst_u'(in_inst_i)),
		.rt_value_i  (reg2), // forwarded rt for movn/movz
		.aluop_o     (aluop),
		.alusel_o    (alusel),
		.wreg_o      (wreg),
		.wd_o        (wd),
		.reg1_read_o (reg1_read),
		.reg2_read_o (reg2_read),
		.reg1_addr_o (reg1_addr),
		.reg2_addr_o (reg2_addr),
		.imm_o       (imm),
		.illegal_o   (illegal)
	);

	regfile u_rf (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.wb_i     (wb_i),
		.raddr1_i (reg1_addr),
		.raddr2_i (reg2_addr),
		.rdata1_o (rf_data1),
		.rdata2_o (rf_data2)
	);

	operand_fwd u_fwd1 (
		.read_i    (reg1_read),
		.addr_i    (reg1_addr),
		.rf_data_i (rf_data1),
		.imm_i     (imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.operand_o (reg1)
	);

	operand_fwd u_fwd2 (
		.read_i    (reg2_read),
		.addr_i    (reg2_addr),
		.rf_data_i (rf_data2),
		.imm_i     (imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.operand_o (reg2)
	);

	assign dec_bundle = '{pc: in_pc_i, aluop: aluop, alusel: alusel, reg1: reg1,
		reg2: reg2, wd: wd, wreg: wreg, illegal: illegal};

	id_ex_reg u_idex (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (in_valid_i),
		.in_ready_o  (in_ready_o),
		.in_data_i   (dec_bundle),
		.out_valid_o (out_valid_o),
		.out_ready_i (out_ready_i),
		.out_data_o  (out_o)
	);

endmodule

/* bench/id_stage_vectors.svh */
typedef enum logic [1:0] {WR_NO, WR_YES, WR_MOVN, WR_MOVZ} wr_kind_t; // expected wreg rule

typedef struct packed {
	logic [63:0] name; // up to 8 chars
	word_t       inst;
	fwd_t        ex;
	fwd_t        mem;
	aluop_t      aluop;
	alusel_t     alusel;
	reg_addr_t   wd;
	wr_kind_t    wr;
	logic        illegal;
	logic        rd1; // reg1 comes from rs
	logic        rd2; // reg2 comes from rt
	word_t       imm; // operand when not read
} vec_t;

vec_t vecs [38] = '{
	'{"or", 32'h00221825, '0, '0, ALU_OR, SEL_LOGIC, 5'd3, WR_YES, 1'b0, 1'b1, 1'b1, '0},
	'{"and", 32'h00221824, '0, '0, ALU_AND, SEL_LOGIC, 5'd3, WR_YES, 1'b0, 1'b1, 1'b1, '0},
	'{"xor", 32'h00221826, '0, '0, ALU_XOR, SEL_LOGIC, 5'd3, WR_YES, 1'b0, 1'b1, 1'b1, '0},
	'{"nor", 32'h00221827, '0, '0, ALU_NOR, SEL_LOGIC, 5'd3, WR_YES, 1'b0, 1'b1, 1'b1, '0},
	'{"sllv", 32'h00221804, '0, '0, ALU_SLL, SEL_SHIFT, 5'd3, WR_YES, 1'b0, 1'b1, 1'b1, '0},
	'{"srlv", 32'h00221806, '0, '0, ALU_SRL, SEL_SHIFT, 5'd3, WR_YES, 1'b0, 1'b1, 1'b1, '0},
	'{"srav", 32'h00221807, '0, '0, ALU_SRA, SEL_SHIFT, 5'd3, WR_YES, 1'b0, 1'b1, 1'b1, '0},
	'{"slt", 32'h0022182A, '0, '0, ALU_SLT, SEL_ARITH, 5'd3, WR_YES, 1'b0, 1'b1, 1'b1, '0},
	'{"sltu", 32'h0022182B, '0, '0, ALU_SLTU, SEL_ARITH, 5'd3, WR_YES, 1'b0, 1'b1, 1'b1, '0},
	'{"add", 32'h00853020, '0, '0, ALU_ADD, SEL_ARITH, 5'd6, WR_YES, 1'b0, 1'b1, 1'b1, '0},
	'{"addu", 32'h00221821, '0, '0, ALU_ADDU, SEL_ARITH, 5'd3, WR_YES, 1'b0, 1'b1, 1'b1, '0},
	'{"sub", 32'h00E84822, '0, '0, ALU_SUB, SEL_ARITH, 5'd9, WR_YES, 1'b0, 1'b1, 1'b1, '0},
	'{"subu", 32'h00221823, '0, '0, ALU_SUBU, SEL_ARITH, 5'd3, WR_YES, 1'b0, 1'b1, 1'b1, '0},
	'{"sll", 32'h00021940, '0, '0, ALU_SLL, SEL_SHIFT, 5'd3, WR_YES, 1'b0, 1'b0, 1'b1, 32'd5},
	'{"srl", 32'h00021942, '0, '0, ALU_SRL, SEL_SHIFT, 5'd3, WR_YES, 1'b0, 1'b0, 1'b1, 32'd5},
	'{"sra", 32'h00021943, '0, '0, ALU_SRA, SEL_SHIFT, 5'd3, WR_YES, 1'b0, 1'b0, 1'b1, 32'd5},
	'{"clz", 32'h714B5820, '0, '0, ALU_CLZ, SEL_ARITH, 5'd11, WR_YES, 1'b0, 1'b1, 1'b0, '0},
	'{"clo", 32'h714B5821, '0, '0, ALU_CLO, SEL_ARITH, 5'd11, WR_YES, 1'b0, 1'b1, 1'b0, '0},
	'{"ori", 32'h34248421, '0, '0, ALU_OR, SEL_LOGIC, 5'd4, WR_YES, 1'b0, 1'b1, 1'b0, 32'h00008421},
	'{"andi", 32'h3045F0F0, '0, '0, ALU_AND, SEL_LOGIC, 5'd5, WR_YES, 1'b0, 1'b1, 1'b0, 32'h0000F0F0},
	'{"xori", 32'h38661234, '0, '0, ALU_XOR, SEL_LOGIC, 5'd6, WR_YES, 1'b0, 1'b1, 1'b0, 32'h00001234},
	'{"lui", 32'h3C07BEEF, '0, '0, ALU_OR, SEL_LOGIC, 5'd7, WR_YES, 1'b0, 1'b1, 1'b0, 32'hBEEF0000},
	'{"slti", 32'h29098000, '0, '0, ALU_SLT, SEL_ARITH, 5'd9, WR_YES, 1'b0, 1'b1, 1'b0, 32'hFFFF8000},
	'{"sltiu", 32'h2D09FFFE, '0, '0, ALU_SLTU, SEL_ARITH, 5'd9, WR_YES, 1'b0, 1'b1, 1'b0, 32'hFFFFFFFE},
	'{"addi", 32'h218D7FFF, '0, '0, ALU_ADDI, SEL_ARITH, 5'd13, WR_YES, 1'b0, 1'b1, 1'b0, 32'h00007FFF},
	'{"addiu", 32'h258E9ABC, '0, '0, ALU_ADDIU, SEL_ARITH, 5'd14, WR_YES, 1'b0, 1'b1, 1'b0, 32'hFFFF9ABC},
	'{"fwd_both", 32'h00221825, '{1'b1, 5'd1, 32'hE0E0E0E0}, '{1'b1, 5'd1, 32'h3E3E3E3E},
		ALU_OR, SEL_LOGIC, 5'd3, WR_YES, 1'b0, 1'b1, 1'b1, '0},
	'{"fwd_mem", 32'h00221825, '{1'b1, 5'd9, 32'h11111111}, '{1'b1, 5'd1, 32'h3E3E3E3E},
		ALU_OR, SEL_LOGIC, 5'd3, WR_YES, 1'b0, 1'b1, 1'b1, '0},
	'{"fwd_off", 32'h00221825, '{1'b0, 5'd1, 32'h22222222}, '{1'b0, 5'd2, 32'h33333333},
		ALU_OR, SEL_LOGIC, 5'd3, WR_YES, 1'b0, 1'b1, 1'b1, '0},
	'{"fwd_rt", 32'h00221825, '0, '{1'b1, 5'd2, 32'h44444444},
		ALU_OR, SEL_LOGIC, 5'd3, WR_YES, 1'b0, 1'b1, 1'b1, '0},
	'{"movn", 32'h0022180B, '0, '0, ALU_MOVN, SEL_MOVE, 5'd3, WR_MOVN, 1'b0, 1'b1, 1'b1, '0},
	'{"movn_z", 32'h0022180B, '{1'b1, 5'd2, 32'h0}, '0,
		ALU_MOVN, SEL_MOVE, 5'd3, WR_MOVN, 1'b0, 1'b1, 1'b1, '0},
	'{"movz", 32'h0022180A, '0, '0, ALU_MOVZ, SEL_MOVE, 5'd3, WR_MOVZ, 1'b0, 1'b1, 1'b1, '0},
	'{"movz_z", 32'h0022180A, '{1'b1, 5'd2, 32'h0}, '0,
		ALU_MOVZ, SEL_MOVE, 5'd3, WR_MOVZ, 1'b0, 1'b1, 1'b1, '0},
	'{"sync", 32'h0000000F, '0, '0, ALU_NOP, SEL_NOP, 5'd0, WR_NO, 1'b1, 1'b0, 1'b0, '0},
	'{"pref", 32'hCC220010, '0, '0, ALU_NOP, SEL_NOP, 5'd0, WR_NO, 1'b1, 1'b0, 1'b0, '0},
	'{"mult", 32'h00220018, '0, '0, ALU_NOP, SEL_NOP, 5'd0, WR_NO, 1'b1, 1'b0, 1'b0, '0},
	'{"badop", 32'hFC000000, '0, '0, ALU_NOP, SEL_NOP, 5'd0, WR_NO, 1'b1, 1'b0, 1'b0, '0}
};

/* bench/id_stage_tb.sv */
`timescale 1ns/1ps

module id_stage_tb import id_pkg::*; ();

	logic    clk;
	logic    rst_n;
	logic    in_valid;
	logic    in_ready;
	word_t   in_pc;
	word_t   in_inst;
	fwd_t    ex_fwd;
	fwd_t    mem_fwd;
	wb_t     wb;
	logic    out_valid;
	logic    out_ready;
	id_out_t out_bundle;

	word_t   preset [NUM_REGS];
	integer  seed;
	int      errors;
	int      tests;

	`include "id_stage_vectors.svh"

	id_stage UUT (
		.clk_i       (clk),
		.rst_n_i     (rst_n),
		.in_valid_i  (in_valid),
		.in_ready_o  (in_ready),
		.in_pc_i     (in_pc),
		.in_inst_i   (in_inst),
		.ex_fwd_i    (ex_fwd),
		.mem_fwd_i   (mem_fwd),
		.wb_i        (wb),
		.out_valid_o (out_valid),
		.out_ready_i (out_ready),
		.out_o       (out_bundle)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		#(($size(vecs) + 40) * 20 * 4);
		$display("watchdog expired before all table rows came out of the stage");
		$display("Result: FAILED");
		$finish;
	end

	function automatic word_t pc_of(int i);
		return 32'h0040_0000 + (word_t'(i) << 2);
	endfunction

	function automatic string name_of(int i);
		return string'(vecs[i].name);
	endfunction

	// ex beats mem beats the register file
	function automatic word_t newest_value(reg_addr_t r, fwd_t ex, fwd_t mem);
		if (ex.wreg && ex.wd == r) begin
			return ex.wdata;
		end
		if (mem.wreg && mem.wd == r) begin
			return mem.wdata;
		end
		return preset[r];
	endfunction

	function automatic id_out_t expected_bundle(int i);
		vec_t    v;
		inst_u   w;
		id_out_t e;
		v = vecs[i];
		w = v.inst;
		e.pc      = pc_of(i);
		e.aluop   = v.aluop;
		e.alusel  = v.alusel;
		e.wd      = v.wd;
		e.illegal = v.illegal;
		e.reg1    = v.rd1 ? newest_value(w.r.rs, v.ex, v.mem) : v.imm;
		e.reg2    = v.rd2 ? newest_value(w.r.rt, v.ex, v.mem) : v.imm;
		case (v.wr)
			WR_YES:  e.wreg = 1'b1;
			WR_MOVN: e.wreg = (e.reg2 != '0); // rt seen after forwarding
			WR_MOVZ: e.wreg = (e.reg2 == '0);
			default: e.wreg = 1'b0;
		endcase
		return e;
	endfunction

	task automatic check_bundle(input string name, input id_out_t exp, input id_out_t act);
		if (act !== exp) begin
			errors++;
			$display("ERR %0s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("ERR %0s: expected %b, actual %b", name, exp, act);
		end
	endtask

	initial begin
		int      sent;
		int      done;
		int      errs_at;
		logic    stalled;
		logic    lost;
		id_out_t held;
		seed      = 28;
		errors    = 0;
		tests     = 0;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_pc     = '0;
		in_inst   = '0;
		ex_fwd    = '0;
		mem_fwd   = '0;
		wb        = '0;
		out_ready = 1'b0;
		sent      = 0;
		done      = 0;
		stalled   = 1'b0;
		lost      = 1'b0;
		held      = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		#1;
		errs_at = errors;
		check_flag("reset_valid", 1'b0, out_valid);
		check_flag("reset_ready", 1'b1, in_ready);
		tests++;
		if (errors == errs_at) begin
			$display("reset ok");
		end

		preset[0] = '0;
		for (int r = 1; r < NUM_REGS; r++) begin
			@(negedge clk);
			preset[r] = $random(seed);
			wb = '{we: 1'b1, waddr: reg_addr_t'(r), wdata: preset[r]};
		end
		@(negedge clk);
		wb = '0;

		while (done < $size(vecs) && !lost) begin
			@(negedge clk);
			if (stalled) begin
				check_flag("stall_valid", 1'b1, out_valid);
				check_bundle("stall_hold", held, out_bundle);
			end
			if (sent < $size(vecs)) begin
				in_valid = 1'b1;
				in_pc    = pc_of(sent);
				in_inst  = vecs[sent].inst;
				ex_fwd   = vecs[sent].ex;
				mem_fwd  = vecs[sent].mem;
			end else begin
				in_valid = 1'b0;
			end
			out_ready = (($random(seed) & 3) != 0); // ready about 3 cycles in 4
			#1;
			if (sent > done && !out_valid) begin
				errors++;
				lost = 1'b1;
				$display("row %0d was accepted but out_valid_o stayed low", done);
			end else if (out_valid && out_ready) begin
				errs_at = errors;
				check_bundle(name_of(done), expected_bundle(done), out_bundle);
				tests++;
				if (errors == errs_at) begin
					$display("%0s ok", name_of(done));
				end
				done++;
			end
			if (in_valid && in_ready) begin
				sent++;
			end
			stalled = out_valid && !out_ready;
			held    = out_bundle;
		end

		@(negedge clk);
		in_valid = 1'b0;
		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+bench
verilog/id_pkg.sv
verilog/inst_decoder.sv
verilog/operand_fwd.sv
verilog/regfile.sv
verilog/id_ex_reg.sv
verilog/id_stage.sv
bench/id_stage_tb.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - verilog/id_pkg.sv
  - verilog/inst_decoder.sv
  - verilog/operand_fwd.sv
  - verilog/regfile.sv
  - verilog/id_ex_reg.sv
  - verilog/id_stage.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/id_stage_tb.sv
